//--- files.f
+incdir+design
+incdir+dv
design/sched_pkg.sv
design/mem_cmd_pkg.sv
design/chn_request_confirm.sv
design/chn_age_counters.sv
design/age_index_max.sv
design/burst_timer.sv
design/grant_sequencer.sv
design/mem_scheduler_top.sv
dv/tb_mem_scheduler.sv

//--- Bender.yml
package:
  name: mem_scheduler

export_include_dirs:
  - design

sources:
  - files:
      - design/sched_pkg.sv
      - design/mem_cmd_pkg.sv
      - design/chn_request_confirm.sv
      - design/chn_age_counters.sv
      - design/age_index_max.sv
      - design/burst_timer.sv
      - design/grant_sequencer.sv
      - design/mem_scheduler_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mem_scheduler.sv

//--- dv/sched_ref_model.svh
/*
 * reference model: priorities, confirmed want/need sets, ages,
 * sequencer credits and the expected oldest winner
 */
`ifndef SCHED_REF_MODEL_SVH
`define SCHED_REF_MODEL_SVH

age_t      m_pri [`SCHED_N_CHN];
age_t      m_age [`SCHED_N_CHN];
chn_mask_t m_want;    // confirmed want requests
chn_mask_t m_need;    // confirmed need requests
chn_mask_t m_new;     // confirmed last edge, age loads next edge
int        m_credits; // free slots in the sequencer queue

task automatic model_reset();
    for (int i = 0; i < `SCHED_N_CHN; i++) begin
        m_pri[i] = '0;
        m_age[i] = '0;
    end
    m_want    = '0;
    m_need    = '0;
    m_new     = '0;
    m_credits = `SCHED_CREDITS;
endtask

// scan upward, the lowest waiting channel is confirmed first
function automatic chn_mask_t first_waiting(input chn_mask_t m);
    for (int i = 0; i < `SCHED_N_CHN; i++) begin
        if (m[i]) return chn_mask_t'(1) << i;
    end
    return '0;
endfunction

// one clock edge, with the inputs that were present before it
task automatic model_tick(input chn_req_t r, input pgm_t p, input chn_mask_t srv,
                          input logic ret);
    chn_mask_t nw;
    chn_mask_t nn;
    nw = first_waiting(r.want & r.en & ~m_want);
    nn = first_waiting(r.need & r.en & ~m_need);
    for (int i = 0; i < `SCHED_N_CHN; i++) begin
        if (m_new[i]) m_age[i] = m_pri[i];                   // start at priority
        else if (m_age[i] != '1) m_age[i] = m_age[i] + 1'b1; // no wrap
    end
    m_new  = nw | nn;
    m_want = (m_want & r.want & r.en & ~srv) | nw;
    m_need = (m_need & r.need & r.en & ~srv) | nn;
    if (p.en) m_pri[p.addr] = p.data;
    if (ret) m_credits++;
endtask

// oldest eligible channel, need set only when an enabled need is up
function automatic mem_cmd_t model_expected(input chn_req_t r);
    mem_cmd_t  e;
    chn_mask_t elig;
    age_t      best;
    e      = '0;
    best   = '0;
    e.need = |(r.need & r.en);
    elig   = e.need ? m_need : m_want;
    for (int i = 0; i < `SCHED_N_CHN; i++) begin
        if (elig[i] && (!e.valid || m_age[i] > best)) begin // equal age keeps lower index
            e.valid = 1'b1;
            e.chn   = chn_idx_t'(i);
            best    = m_age[i];
        end
    end
    return e;
endfunction

`endif

//--- dv/tb_mem_scheduler.sv
/*
 * scheduler testbench: fixed latency, priority order, need precedence,
 * credit back-pressure and a random phase checked against the model
 */
`default_nettype none

`include "sched_defs.svh"

module tb_mem_scheduler;
    timeunit 1ns;
    timeprecision 100ps;

    import sched_pkg::*;
    import mem_cmd_pkg::*;

    localparam int N_RAND  = 40; // grants in the random phase
    localparam int N_TRANS = 1 + 5 + 3 + (`SCHED_CREDITS + 2) + N_RAND;
    localparam int MAX_CYC = 20 * N_TRANS * (`SCHED_BURST_LEN + 6);
    localparam int GAP_MIN = `SCHED_BURST_LEN + 2; // closest legal grant spacing
    localparam int ORDER [5] = '{7, 13, 2, 9, 11};  // descending priority with the tie to ch2

    logic      clk;
    logic      mrst;
    chn_req_t  req;
    pgm_t      pgm;
    logic      credit_ret;
    mem_cmd_t  cmd;
    chn_mask_t served;

    `include "sched_ref_model.svh"

    int          cyc = 0;      // clock edges since time zero
    int          n_grant;
    int          last_grant;   // edge count of the previous grant
    logic        auto_credit;  // sequencer frees a slot right away
    logic        check_winner; // grants must match the model winner
    chn_mask_t   served_prev;  // served as the DUT saw it at this edge
    logic [31:0] rng;

    mem_scheduler_top i_mem_scheduler_top (
        .clk        (clk),
        .mrst       (mrst),
        .req        (req),
        .pgm        (pgm),
        .credit_ret (credit_ret),
        .cmd        (cmd),
        .served     (served)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= MAX_CYC) begin
            $display("timeout: no end of test after %0d cycles", cyc);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mem_cmd_t make_cmd(input logic v, input int ch, input logic nd);
        mem_cmd_t c;
        c.valid = v;
        c.chn   = chn_idx_t'(ch);
        c.need  = nd;
        return c;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // chn and need only matter when a command is expected
    task automatic check_cmd(input mem_cmd_t got, input mem_cmd_t exp, input string what);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.chn !== exp.chn || got.need !== exp.need))) begin
            report_error($sformatf(
                "%s: cmd v=%0b chn=%0d need=%0b, expected v=%0b chn=%0d need=%0b",
                what, got.valid, got.chn, got.need, exp.valid, exp.chn, exp.need));
        end
    endtask

    task automatic check_served(input chn_mask_t got, input chn_mask_t exp, input string what);
        if (got !== exp) report_error($sformatf("%s: served %h, expected %h", what, got, exp));
    endtask

    // sample one clock after the edge, check, then update model, client and sequencer
    task automatic step();
        chn_idx_t  ch;
        chn_mask_t exp_srv;
        @(posedge clk);
        #1;
        ch      = cmd.chn;
        exp_srv = cmd.valid ? chn_mask_t'(1) << ch : '0;
        check_served(served, exp_srv, "served pulse");
        if (cmd.valid) begin
            if (check_winner) check_cmd(cmd, model_expected(req), "oldest winner");
            if (!(req.en[ch] && (req.want[ch] || req.need[ch])) || (cmd.need && !req.need[ch]))
                report_error($sformatf("grant to channel %0d with no such pending request", ch));
            if (m_credits == 0) report_error("command issued with no credit left");
            if (cyc - last_grant < GAP_MIN)
                report_error($sformatf("grants only %0d cycles apart", cyc - last_grant));
            m_credits--;
            last_grant = cyc;
            n_grant++;
        end
        model_tick(req, pgm, served_prev, credit_ret);
        served_prev = served;
        req.want &= ~served; // client drops a served request
        req.need &= ~served;
        pgm.en     = 1'b0;
        credit_ret = auto_credit && (m_credits < `SCHED_CREDITS);
    endtask

    task automatic write_pri(input int ch, input age_t val);
        pgm.en   = 1'b1;
        pgm.addr = chn_idx_t'(ch);
        pgm.data = val;
        step();
    endtask

    task automatic wait_grant();
        int n0;
        n0 = n_grant;
        while (n_grant == n0) step(); // cycle limit catches a missing grant
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            step();
            check_cmd(cmd, make_cmd(1'b0, 0, 1'b0), "no grant without credit");
        end
    endtask

    initial begin
        chn_idx_t ch;
        int       n0;
        mrst         = 1'b1;
        req          = '0;
        pgm          = '0;
        credit_ret   = 1'b0;
        auto_credit  = 1'b1;
        check_winner = 1'b1;
        served_prev  = '0;
        rng          = 32'd43418;
        n_grant      = 0;
        last_grant   = -1000;
        model_reset();
        repeat (10) @(posedge clk);
        #1;
        mrst   = 1'b0;
        req.en = '1;

        write_pri(2, 16'h0300); // same priority as ch9
        write_pri(7, 16'h0800);
        write_pri(9, 16'h0300);
        write_pri(11, 16'h0100);
        write_pri(13, 16'h0600);
        repeat (2) step();

        // lone request on an idle scheduler
        req.want[5] = 1'b1;
        for (int k = 1; k <= 5; k++) begin
            step();
            check_cmd(cmd, make_cmd(k == 5, 5, 1'b0), "single request latency");
            check_served(served, (k == 5) ? chn_mask_t'(1) << 5 : '0, "single request served");
        end

        // raised together while the bus is still busy with ch5
        req.want |= chn_mask_t'(16'h2A84);
        for (int i = 0; i < 5; i++) begin
            wait_grant();
            check_cmd(cmd, make_cmd(1'b1, ORDER[i], 1'b0), "priority order");
        end

        // need raised after two wants still wins
        req.want[3] = 1'b1;
        req.want[4] = 1'b1;
        repeat (3) step();
        req.need[10] = 1'b1;
        wait_grant();
        check_cmd(cmd, make_cmd(1'b1, 10, 1'b1), "need precedence");
        wait_grant();
        check_cmd(cmd, make_cmd(1'b1, 3, 1'b0), "older want after need");
        wait_grant();
        check_cmd(cmd, make_cmd(1'b1, 4, 1'b0), "younger want after need");

        // back-pressure with the sequencer holding all slots
        check_winner = 1'b0;
        while (m_credits < `SCHED_CREDITS) step();
        auto_credit = 1'b0;
        credit_ret  = 1'b0;
        req.want |= chn_mask_t'(16'hD143); // seven channels for four credits
        repeat (`SCHED_CREDITS) wait_grant();
        expect_quiet(3 * GAP_MIN);
        repeat (2) begin
            credit_ret = 1'b1; // single returned slot
            wait_grant();
            expect_quiet(3 * GAP_MIN);
        end

        // random traffic with legality and spacing checked in step
        n0 = n_grant;
        while (n_grant - n0 < N_RAND) begin
            step();
            rng = xorshift32(rng);
            ch  = rng[3:0];
            if (rng[5:4] == 2'd0 && req.en[ch] && !(req.want[ch] || req.need[ch])) begin
                if (rng[7:6] == 2'd0) req.need[ch] = 1'b1;
                else req.want[ch] = 1'b1;
            end
            ch = rng[11:8];
            if (rng[15:12] == 4'd0 && !(req.want[ch] || req.need[ch]))
                req.en[ch] = ~req.en[ch]; // only idle channels change enable
            if (rng[19:16] == 4'd0) begin
                pgm.en   = 1'b1;
                pgm.addr = rng[23:20];
                pgm.data = {rng[31:24], 8'h00};
            end
            rng        = xorshift32(rng);
            credit_ret = (rng[1:0] == 2'd0) && (m_credits < `SCHED_CREDITS);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/mem_scheduler_top.sv
/*
 * scheduler top: request confirmation, age counters, oldest search,
 * burst timer and grant FSM
 */
`default_nettype none

`include "sched_defs.svh"

module mem_scheduler_top (
    input  wire                   clk,
    input  wire                   mrst,
    input  wire sched_pkg::chn_req_t   req,
    input  wire sched_pkg::pgm_t       pgm,
    input  wire                   credit_ret,
    output mem_cmd_pkg::mem_cmd_t cmd,
    output sched_pkg::chn_mask_t  served
);
    import sched_pkg::*;

    chn_mask_t want_conf;
    chn_mask_t need_conf;
    chn_mask_t new_conf;
    chn_mask_t sel_mask;   // need set when any enabled need is up
    age_t      ages [`SCHED_N_CHN];
    logic      need_some;
    chn_idx_t  idx;
    logic      idx_valid;
    logic      is_need;
    logic      bus_free;
    logic      start;

    assign need_some = |(req.need & req.en);
    assign sel_mask  = need_some ? need_conf : want_conf;

    chn_request_confirm i_chn_request_confirm (
        .clk       (clk),
        .mrst      (mrst),
        .req       (req),
        .served    (served),
        .want_conf (want_conf),
        .need_conf (need_conf),
        .new_conf  (new_conf)
    );

    chn_age_counters i_chn_age_counters (
        .clk      (clk),
        .mrst     (mrst),
        .pgm      (pgm),
        .new_conf (new_conf),
        .ages     (ages)
    );

    age_index_max i_age_index_max (
        .clk       (clk),
        .ages      (ages),
        .mask      (sel_mask),  // aligned with the ages inside
        .need_in   (need_some),
        .idx       (idx),
        .idx_valid (idx_valid),
        .is_need   (is_need)
    );

    burst_timer i_burst_timer (
        .clk      (clk),
        .mrst     (mrst),
        .start    (start),
        .bus_free (bus_free)
    );

    grant_sequencer i_grant_sequencer (
        .clk        (clk),
        .mrst       (mrst),
        .idx        (idx),
        .idx_valid  (idx_valid),
        .is_need    (is_need),
        .bus_free   (bus_free),
        .credit_ret (credit_ret),
        .cmd        (cmd),
        .served     (served),
        .start      (start)
    );

endmodule

`default_nettype wire

//--- design/grant_sequencer.sv
/*
 * grant FSM: issues one command per winner while credits remain,
 * tracks sequencer credits and pulses served and the burst start
 */
`default_nettype none

`include "sched_defs.svh"

module grant_sequencer (
    input  wire                  clk,
    input  wire                  mrst,
    input  wire sched_pkg::chn_idx_t  idx,
    input  wire                  idx_valid,
    input  wire                  is_need,
    input  wire                  bus_free,
    input  wire                  credit_ret, // one credit back per high cycle
    output mem_cmd_pkg::mem_cmd_t cmd,
    output sched_pkg::chn_mask_t served,    // one-cycle pulse on the granted channel
    output logic                 start      // kicks the burst timer
);
    import sched_pkg::*;
    import mem_cmd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_CREDIT, // winner pending, queue full
        ISSUE,       // cmd and served out this cycle
        BUSY         // bus occupied by the last grant
    } state_t;

    state_t  state;
    credit_t credits;
    logic    grant_w;

    assign grant_w = ((state == IDLE) || (state == WAIT_CREDIT)) &&
                     idx_valid && (credits != '0);

    always_ff @(posedge clk) begin
        if (mrst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:        if (grant_w) state <= ISSUE;
                             else if (idx_valid) state <= WAIT_CREDIT; // no credit
                WAIT_CREDIT: if (grant_w) state <= ISSUE;
                             else if (!idx_valid) state <= IDLE;       // request withdrawn
                ISSUE:       state <= BUSY; // timer loads at the end of ISSUE
                BUSY:        if (bus_free) state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    // a grant takes a slot, credit_ret gives one back, both may coincide
    always_ff @(posedge clk) begin
        if (mrst) begin
            credits <= CREDITS_RST;
        end else begin
            credits <= credits + credit_t'(credit_ret) - credit_t'(grant_w);
        end
    end

    always_ff @(posedge clk) begin
        if (mrst) begin
            cmd    <= '0;
            served <= '0;
        end else begin
            cmd.valid <= grant_w;
            served    <= grant_w ? (chn_mask_t'(1) << idx) : '0;
            if (grant_w) begin
                cmd.chn  <= idx;
                cmd.need <= is_need;
            end
        end
    end

    assign start = (state == ISSUE); // same cycle as cmd.valid

    // the sequencer never returns more credits than it has slots
    a_credit_max: assert property (@(posedge clk) disable iff (mrst)
        credits <= credit_t'(`SCHED_CREDITS))
        else $error("grant_sequencer: credit count above queue depth");

endmodule

`default_nettype wire

//--- design/burst_timer.sv
/*
 * bus occupancy timer, reloaded on each grant
 */
`default_nettype none

`include "sched_defs.svh"

module burst_timer (
    input  wire  clk,
    input  wire  mrst,
    input  wire  start,    // grant issued this cycle
    output logic bus_free  // previous access has left the bus
);
    localparam int CNT_W = $clog2(`SCHED_BURST_LEN + 1);

    logic [CNT_W-1:0] cnt; // cycles of bus time left

    always_ff @(posedge clk) begin
        if (mrst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= CNT_W'(`SCHED_BURST_LEN);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign bus_free = (cnt == '0); // also high straight out of reset

    // the sequencer must wait for the bus before granting again
    a_start_when_free: assert property (@(posedge clk) disable iff (mrst)
        start |-> bus_free)
        else $error("burst_timer: grant while bus still busy");

endmodule

`default_nettype wire

//--- design/age_index_max.sv
/*
 * oldest channel search: mask alignment, then two register stages each
 * reducing groups of four, ties resolved toward the lower index
 */
`default_nettype none

`include "sched_defs.svh"

module age_index_max (
    input  wire                  clk,
    input  wire sched_pkg::age_t      ages [`SCHED_N_CHN],
    input  wire sched_pkg::chn_mask_t mask,    // eligible channels, current cycle
    input  wire                  need_in, // mask came from the need set
    output sched_pkg::chn_idx_t  idx,
    output logic                 idx_valid,
    output logic                 is_need
);
    import sched_pkg::*;

    localparam int N_GRP = `SCHED_N_CHN / 4; // first stage groups

    chn_mask_t mask_d;   // mask one cycle late
    chn_mask_t mask_eff; // on after one cycle, off at once

    // stage 1 combinational best per group
    age_t     g_age [N_GRP];
    chn_idx_t g_idx [N_GRP];
    logic     g_vld [N_GRP];

    // stage 1 registers
    age_t     s1_age [N_GRP];
    chn_idx_t s1_idx [N_GRP];
    logic     s1_vld [N_GRP];
    logic     s1_need;

    // stage 2 combinational winner
    age_t     w_age;
    chn_idx_t w_idx;
    logic     w_vld;

    // a channel must wait one cycle after confirmation for its loaded age
    assign mask_eff = mask & mask_d;

    always_comb begin
        for (int g = 0; g < N_GRP; g++) begin
            g_vld[g] = 1'b0;
            g_age[g] = '0;
            g_idx[g] = chn_idx_t'(4 * g);
            for (int k = 0; k < 4; k++) begin
                // strict compare keeps the lower index on a tie
                if (mask_eff[4*g+k] && (!g_vld[g] || (ages[4*g+k] > g_age[g]))) begin
                    g_vld[g] = 1'b1;
                    g_age[g] = ages[4*g+k];
                    g_idx[g] = chn_idx_t'(4 * g + k);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        mask_d  <= mask;
        s1_age  <= g_age;
        s1_idx  <= g_idx;
        s1_vld  <= g_vld;
        s1_need <= need_in; // travels with the stage 1 results
    end

    always_comb begin
        w_vld = 1'b0;
        w_age = '0;
        w_idx = '0;
        for (int g = 0; g < N_GRP; g++) begin
            if (s1_vld[g] && (!w_vld || (s1_age[g] > w_age))) begin
                w_vld = 1'b1;
                w_age = s1_age[g];
                w_idx = s1_idx[g];
            end
        end
    end

    always_ff @(posedge clk) begin
        idx       <= w_idx;
        idx_valid <= w_vld;
        is_need   <= s1_need;
    end

endmodule

`default_nettype wire

//--- design/chn_age_counters.sv
/*
 * priority register file written by the host, and one saturating age
 * counter per channel loaded from its priority on confirmation
 */
`default_nettype none

`include "sched_defs.svh"

module chn_age_counters (
    input  wire                  clk,
    input  wire                  mrst,
    input  wire sched_pkg::pgm_t      pgm,
    input  wire sched_pkg::chn_mask_t new_conf,
    output sched_pkg::age_t      ages [`SCHED_N_CHN]
);
    import sched_pkg::*;

    age_t pri [`SCHED_N_CHN]; // programmed start priorities

    // host programming, one channel per cycle
    always_ff @(posedge clk) begin
        if (mrst) begin
            for (int i = 0; i < `SCHED_N_CHN; i++) begin
                pri[i] <= '0;
            end
        end else if (pgm.en) begin
            pri[pgm.addr] <= pgm.data;
        end
    end

    /*
     * a confirmed channel starts at its priority and gets older every
     * cycle, so a low priority request still wins eventually.
     * counters stop at all ones instead of wrapping to the youngest age
     */
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SCHED_N_CHN; i++) begin
            if (new_conf[i]) begin
                ages[i] <= pri[i];            // age valid one cycle after confirm
            end else if (~&ages[i]) begin
                ages[i] <= ages[i] + 1'b1;    // saturate at max
            end
        end
    end

endmodule

`default_nettype wire

//--- design/chn_request_confirm.sv
/*
 * request confirmation: picks at most one new want and one new need per
 * cycle (lowest index first), holds confirmed bits until served or dropped
 */
`default_nettype none

module chn_request_confirm (
    input  wire                  clk,
    input  wire                  mrst,
    input  wire sched_pkg::chn_req_t  req,
    input  wire sched_pkg::chn_mask_t served,
    output sched_pkg::chn_mask_t want_conf, // held confirmed want requests
    output sched_pkg::chn_mask_t need_conf, // held confirmed need requests
    output sched_pkg::chn_mask_t new_conf   // pulse, channels confirmed this cycle
);
    import sched_pkg::*;

    chn_mask_t want_set;  // new want, 1-hot or zero
    chn_mask_t need_set;  // new need, 1-hot or zero
    chn_mask_t want_next;
    chn_mask_t need_next;

    // isolate lowest set bit, lowest channel has precedence
    function automatic chn_mask_t lowest_1hot(input chn_mask_t m);
        return m & (~m + 1'b1);
    endfunction

    // only enabled requests not yet confirmed compete
    assign want_set = lowest_1hot(req.want & req.en & ~want_conf);
    assign need_set = lowest_1hot(req.need & req.en & ~need_conf);

    // keep while request and enable stay up, drop on the grant pulse
    assign want_next = (want_conf & req.want & req.en & ~served) | want_set;
    assign need_next = (need_conf & req.need & req.en & ~served) | need_set;

    always_ff @(posedge clk) begin
        if (mrst) begin
            want_conf <= '0;
            need_conf <= '0;
            new_conf  <= '0;
        end else begin
            want_conf <= want_next;
            need_conf <= need_next;
            new_conf  <= want_set | need_set; // loads the age counters next edge
        end
    end

    // newly confirmed wants never arrive in pairs, served only clears bits
    a_want_new_1hot: assert property (@(posedge clk) disable iff (mrst)
        $onehot0(want_conf & ~$past(want_conf)))
        else $error("chn_request_confirm: more than one new want confirmed");

endmodule

`default_nettype wire

//--- design/mem_cmd_pkg.sv
/*
 * memory side types: command to the sequencer and credit count,
 * plus the credit count loaded at reset
 */
`default_nettype none

`include "sched_defs.svh"

package mem_cmd_pkg;

    // one command per grant, valid is a single-cycle pulse
    typedef struct packed {
        logic                valid;
        sched_pkg::chn_idx_t chn;  // granted channel
        logic                need; // granted from the need set
    } mem_cmd_t;

    // 0 .. SCHED_CREDITS inclusive
    typedef logic [$clog2(`SCHED_CREDITS + 1)-1:0] credit_t;

    localparam credit_t CREDITS_RST = credit_t'(`SCHED_CREDITS); // queue empty

endpackage

`default_nettype wire

//--- design/sched_pkg.sv
/*
 * client side types: channel index, age/priority value, channel mask,
 * priority programming word and per-channel request bundle
 */
`default_nettype none

`include "sched_defs.svh"

package sched_pkg;

    typedef logic [`SCHED_CHN_W-1:0] chn_idx_t;  // channel number
    typedef logic [`SCHED_AGE_W-1:0] age_t;      // start priority or running age
    typedef logic [`SCHED_N_CHN-1:0] chn_mask_t; // one bit per channel

    // host write of one channel priority
    typedef struct packed {
        logic     en;   // write strobe
        chn_idx_t addr; // channel to program
        age_t     data; // new start priority
    } pgm_t;

    // client requests, held until served
    typedef struct packed {
        chn_mask_t want; // opportunistic access
        chn_mask_t need; // urgent access, beats any want
        chn_mask_t en;   // channel enable
    } chn_req_t;

endpackage

`default_nettype wire

//--- design/sched_defs.svh
/*
 * scheduler build constants: channel count, age and index widths,
 * bus occupancy per grant and sequencer credit depth
 */
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

`define SCHED_N_CHN      16 // client channels
`define SCHED_AGE_W      16 // age counter and priority width
`define SCHED_CHN_W      4  // channel index bits, log2 of SCHED_N_CHN

// cycles the bus stays busy after a granted access
`define SCHED_BURST_LEN  8

// command slots in the sequencer queue, credits held after reset
`define SCHED_CREDITS    4

`endif
